// ==== Bender.yml ====
package:
  name: holdem

sources:
  - include_dirs:
      - source
    files:
      - source/holdem_pkg.sv
      - source/action_decode.sv
      - source/bet_execute.sv
      - source/pot_settle.sv
      - source/holdem_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/holdem_props.sv
      - dv/holdem_checker.sv
      - dv/holdem_tb.sv

// ==== dv/holdem_checker.sv ====
`default_nettype none

module holdem_checker (
    input  wire        clk,
    input  wire        reset_d,
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    input  wire [1:0]  adr,
    input  wire        ack,
    input  wire [7:0]  dat_r,
    input  wire [7:0]  exp_data,
    output int         mismatches,
    output int         reads_checked
);

    logic       pend_read;
    logic [1:0] pend_adr;
    logic [7:0] pend_exp;

    function automatic string reg_name(input logic [1:0] a);
        case (a)
            2'd0:    return "status";
            2'd1:    return "pot";
            2'd2:    return "p1 balance";
            default: return "p2 balance";
        endcase
    endfunction

    initial begin
        mismatches    = 0;
        reads_checked = 0;
        pend_read     = 1'b0;
    end

    // ----------------------------------------------------------------------
    // Latch each request, compare its read data when ack shows up.
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset_d) begin
            pend_read <= 1'b0;
        end else if (cyc && stb && !ack) begin    // Request taken on this edge.
            pend_read <= !we;
            pend_adr  <= adr;
            pend_exp  <= exp_data;
        end else if (ack) begin
            pend_read <= 1'b0;
            if (pend_read) begin
                reads_checked++;
                if (dat_r !== pend_exp) begin
                    $display("Fail t=%0t dat_r (%s): expected 0x%02h, got 0x%02h",
                             $time, reg_name(pend_adr), pend_exp, dat_r);
                    mismatches++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/holdem_props.sv ====
`default_nettype none
`include "holdem_macros.svh"

module holdem_props (
    input wire                      clk,
    input wire                      reset_d,
    input wire                      cyc,
    input wire                      stb,
    input wire                      ack,
    input wire [`HOLDEM_CHIP_W-1:0] pot,
    input wire [`HOLDEM_CHIP_W-1:0] p1_balance,
    input wire [`HOLDEM_CHIP_W-1:0] p2_balance
);

    logic [`HOLDEM_CHIP_W+1:0] chip_sum;
    int                        failures = 0;

    assign chip_sum = pot + p1_balance + p2_balance;    // Chips in play.

    ack_single: assert property (@(posedge clk) disable iff (reset_d) ack |=> !ack)
        else begin failures++; $error("ack stayed high for more than one cycle"); end

    ack_requested: assert property (@(posedge clk) disable iff (reset_d)
        $rose(ack) |-> $past(cyc && stb))
        else begin failures++; $error("ack rose without cyc and stb"); end

    // Odd tie chip may vanish, nothing may appear.
    chips_bounded: assert property (@(posedge clk) disable iff (reset_d)
        (chip_sum <= 2 * `HOLDEM_START_BALANCE) && (chip_sum <= $past(chip_sum)))
        else begin failures++; $error("chip count rose or exceeded the start total"); end

endmodule

bind holdem_top holdem_props u_props (
    .clk(clk), .reset_d(reset_d), .cyc(cyc), .stb(stb), .ack(ack),
    .pot(pot), .p1_balance(p1_balance), .p2_balance(p2_balance)
);

`default_nettype wire

// ==== dv/holdem_tb.sv ====
`default_nettype none
`include "holdem_macros.svh"

module holdem_tb;

    localparam int rec_max = 256;

    logic        clk;
    logic        reset_d;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [7:0]  dat_w;
    logic        hand_win;
    logic        hand_tie;
    logic [7:0]  exp_data;
    wire         ack;
    wire  [7:0]  dat_r;
    int          mismatches;
    int          reads_checked;
    int          timeouts;
    int          file_errors;
    int          rec_done;
    logic [19:0] records [rec_max];     // kind, flags, adr, data.

    holdem_top u_dut (
        .clk(clk), .reset_d(reset_d), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .hand_win(hand_win), .hand_tie(hand_tie), .ack(ack), .dat_r(dat_r)
    );

    holdem_checker u_checker (
        .clk(clk), .reset_d(reset_d), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .ack(ack), .dat_r(dat_r), .exp_data(exp_data), .mismatches(mismatches),
        .reads_checked(reads_checked)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ----------------------------------------------------------------------
    // One Wishbone classic transfer, started just after a rising edge.
    // ----------------------------------------------------------------------
    task automatic bus_transfer(input logic wr, input logic [1:0] addr, input logic [7:0] wdata);
        int   waited;
        logic got_ack;
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = wr;
        adr     = addr;
        dat_w   = wdata;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < 20) begin
            @(posedge clk);
            got_ack = ack;
            waited++;
        end
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (!got_ack) begin
            $display("Error at %0t: no ack from the DUT for address %0d", $time, addr);
            timeouts++;
        end
    endtask

    task automatic idle_gap();
        repeat (1 + ($urandom % 4)) @(posedge clk);
        #1;
    endtask

    initial begin
        int         idx;
        int         assert_fails;
        logic       done;
        logic [3:0] kind;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        hand_win    = 1'b0;
        hand_tie    = 1'b0;
        exp_data    = '0;
        reset_d     = 1'b1;
        timeouts    = 0;
        file_errors = 0;
        rec_done    = 0;
        void'($urandom(32'h3863213a));
        $readmemh("dv/holdem_tests.txt", records);
        repeat (16) @(posedge clk);
        #1;
        reset_d = 1'b0;
        idx     = 0;
        done    = 1'b0;
        while (!done && idx < rec_max) begin
            kind = records[idx][19:16];
            case (kind)
                4'h1: begin                             // Action write.
                    hand_win = records[idx][12];
                    hand_tie = records[idx][13];
                    bus_transfer(1'b1, records[idx][9:8], records[idx][7:0]);
                    rec_done++;
                    idle_gap();
                end
                4'h2: begin                             // Read with expected value.
                    exp_data = records[idx][7:0];
                    bus_transfer(1'b0, records[idx][9:8], 8'h00);
                    rec_done++;
                    idle_gap();
                end
                4'h0: done = 1'b1;
                default: begin
                    $display("Error: test record %0d is unreadable", idx);
                    file_errors++;
                    done = 1'b1;
                end
            endcase
            idx++;
        end
        if (rec_done == 0) begin
            $display("Error: no test records were run");
            file_errors++;
        end
        repeat (2) @(posedge clk);
        assert_fails = u_dut.u_props.failures;
        $write("Errors: %0d read mismatches, %0d missing acks, %0d file errors, ",
               mismatches, timeouts, file_errors);
        $display("%0d assertion failures (%0d records, %0d reads)",
                 assert_fails, rec_done, reads_checked);
        if (mismatches == 0 && timeouts == 0 && file_errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/holdem_tests.txt ====
// Each record is a 5-digit hex word: kind (1 action write, 2 read, 0 end),
// flags (bit 0 hand_win, bit 1 hand_tie), address, then action code or expected byte.
// Reset state.
20000 20100 20231 20331
// Hand 0: checks through every round, showdown with an empty pot.
10002 20004 10002 20001
10002 20005 10002 20002
10002 20006 10002 20003
10002 20007 10002 2000C 20100 20231 20331
// Hand 1: raise and call, then a fold pays player 1.
10003 20008 20105 2032C
10002 2000D 2010A 2022C
10001 20000 20100 20236 2032C
// Hand 2: river raise and call, player 1 wins at showdown.
10002 10002 10002 10002 10002 10002 20003
10003 20105 20231 11002 2000C 20100 2023B 20327
// Hand 3: preflop and river bets, a tie splits the pot.
10003 20008 10003 10002 2000D 20114
10002 20009 10002 2000E 10002 2000A 10002 2000F
10003 13002 20000 20100 2023B 20327
// Hand 4: raises drain player 2, whose next raise is refused.
10003 10003 10003 10003 10003 10003 10003
20004 20141 20218 20309
10003 10103 20004 20141 20218 20309
10002 20001 20146 20304
10001 2000C 20100 20218 2034A
00000

// ==== holdem.f ====
+incdir+source
source/holdem_pkg.sv
source/action_decode.sv
source/bet_execute.sv
source/pot_settle.sv
source/holdem_top.sv
dv/holdem_props.sv
dv/holdem_checker.sv
dv/holdem_tb.sv

// ==== source/action_decode.sv ====
`default_nettype none
`include "holdem_macros.svh"

module action_decode
    import holdem_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_d,
    input  wire                         cyc,
    input  wire                         stb,
    input  wire                         we,
    input  wire [1:0]                   adr,
    input  wire [7:0]                   dat_w,
    input  wire round_e                 round,
    input  wire player_e                cur_player,
    input  wire player_e                start_player,
    input  wire [`HOLDEM_CHIP_W-1:0]    pot,
    input  wire [`HOLDEM_CHIP_W-1:0]    cur_bet,
    input  wire [`HOLDEM_CHIP_W-1:0]    p1_staked,
    input  wire [`HOLDEM_CHIP_W-1:0]    p2_staked,
    input  wire [`HOLDEM_CHIP_W-1:0]    p1_balance,
    input  wire [`HOLDEM_CHIP_W-1:0]    p2_balance,
    output logic                        ack,
    output logic [7:0]                  dat_r,
    output action_e                     act_kind,
    output logic [`HOLDEM_CHIP_W-1:0]   act_amount
);

    logic                       accept;
    logic                       act_write;
    action_e                    opcode;
    logic [`HOLDEM_CHIP_W-1:0]  actor_balance;
    logic [`HOLDEM_CHIP_W-1:0]  actor_staked;
    logic [`HOLDEM_CHIP_W-1:0]  owed;
    logic [`HOLDEM_CHIP_W:0]    cost;
    logic                       affordable;
    logic [7:0]                 read_word;

    // ----------------------------------------------------------------------
    // Bus handshake.
    // ----------------------------------------------------------------------
    assign accept    = cyc && stb && !ack;      // New transfer only.
    assign act_write = accept && we && (adr == `HOLDEM_ADDR_STATUS);
    assign opcode    = action_e'(dat_w[1:0]);

    // ----------------------------------------------------------------------
    // Cost of the action for the player to act.
    // ----------------------------------------------------------------------
    assign actor_balance = (cur_player == player_1) ? p1_balance : p2_balance;
    assign actor_staked  = (cur_player == player_1) ? p1_staked : p2_staked;
    assign owed          = cur_bet - actor_staked;

    always_comb begin
        case (opcode)
            act_check_call: cost = {1'b0, owed};
            act_raise:      cost = {1'b0, owed} + (`HOLDEM_CHIP_W+1)'(`HOLDEM_RAISE_STEP);
            default:        cost = '0;              // Fold costs nothing.
        endcase
    end

    // Extra top bit keeps owed plus step from wrapping.
    assign affordable = ({1'b0, actor_balance} >= cost);

    always_comb begin
        act_kind   = act_none;
        act_amount = '0;
        if (act_write && affordable) begin
            act_kind   = opcode;
            act_amount = cost[`HOLDEM_CHIP_W-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Read multiplexer.
    // ----------------------------------------------------------------------
    always_comb begin
        case (adr)
            `HOLDEM_ADDR_STATUS: begin
                read_word = {4'b0000, start_player, cur_player, round};
            end
            `HOLDEM_ADDR_POT: begin
                read_word = {{(8-`HOLDEM_CHIP_W){1'b0}}, pot};
            end
            `HOLDEM_ADDR_P1: begin
                read_word = {{(8-`HOLDEM_CHIP_W){1'b0}}, p1_balance};
            end
            `HOLDEM_ADDR_P2: begin
                read_word = {{(8-`HOLDEM_CHIP_W){1'b0}}, p2_balance};
            end
            default: begin
                read_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;                      // Drops after one cycle.
        end
    end

    // Sampled before the action lands, so a write returns old state.
    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r <= read_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/bet_execute.sv ====
`default_nettype none
`include "holdem_macros.svh"

module bet_execute
    import holdem_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_d,
    input  wire action_e                act_kind,
    input  wire [`HOLDEM_CHIP_W-1:0]    act_amount,
    output round_e                      round,
    output player_e                     cur_player,
    output player_e                     start_player,
    output logic [`HOLDEM_CHIP_W-1:0]   pot,
    output logic [`HOLDEM_CHIP_W-1:0]   cur_bet,
    output logic [`HOLDEM_CHIP_W-1:0]   p1_staked,
    output logic [`HOLDEM_CHIP_W-1:0]   p2_staked,
    output player_e                     debit_player,
    output logic [`HOLDEM_CHIP_W-1:0]   debit_amount,
    output logic                        settle_fold,
    output logic                        settle_show,
    output player_e                     fold_winner,
    output logic [`HOLDEM_CHIP_W-1:0]   settle_pot
);

    logic [`HOLDEM_HAND_CNT_W-1:0]  hand_cnt;
    logic [`HOLDEM_HAND_CNT_W-1:0]  hand_cnt_nxt;
    round_e                         round_nxt;
    player_e                        cur_player_nxt;
    player_e                        opponent;
    player_e                        next_starter;
    logic [`HOLDEM_CHIP_W-1:0]      pot_nxt;
    logic [`HOLDEM_CHIP_W-1:0]      cur_bet_nxt;
    logic [`HOLDEM_CHIP_W-1:0]      p1_staked_nxt;
    logic [`HOLDEM_CHIP_W-1:0]      p2_staked_nxt;
    logic [`HOLDEM_CHIP_W-1:0]      paid_pot;
    logic                           close_round;
    logic                           end_hand;

    assign start_player = hand_cnt[0] ? player_2 : player_1;   // Alternates per hand.
    assign opponent     = (cur_player == player_1) ? player_2 : player_1;
    assign hand_cnt_nxt = hand_cnt + 1'b1;
    assign next_starter = hand_cnt_nxt[0] ? player_2 : player_1;
    assign paid_pot     = pot + act_amount;

    assign debit_player = cur_player;
    assign fold_winner  = opponent;
    assign settle_pot   = paid_pot;                             // Includes a final call.

    // ----------------------------------------------------------------------
    // Betting state machine.
    // ----------------------------------------------------------------------
    always_comb begin
        round_nxt      = round;
        cur_player_nxt = cur_player;
        pot_nxt        = pot;
        cur_bet_nxt    = cur_bet;
        p1_staked_nxt  = p1_staked;
        p2_staked_nxt  = p2_staked;
        debit_amount   = '0;
        settle_fold    = 1'b0;
        settle_show    = 1'b0;
        close_round    = 1'b0;
        end_hand       = 1'b0;

        case (act_kind)
            act_fold: begin
                settle_fold = 1'b1;
                end_hand    = 1'b1;
            end
            act_check_call: begin
                debit_amount = act_amount;                      // Zero on a check.
                pot_nxt      = paid_pot;
                if (cur_bet != '0 || cur_player != start_player) begin
                    close_round = 1'b1;
                end else begin
                    cur_player_nxt = opponent;
                end
            end
            act_raise: begin
                debit_amount   = act_amount;
                pot_nxt        = paid_pot;
                cur_bet_nxt    = cur_bet + `HOLDEM_CHIP_W'(`HOLDEM_RAISE_STEP);
                cur_player_nxt = opponent;
                if (cur_player == player_1) begin
                    p1_staked_nxt = cur_bet_nxt;
                end else begin
                    p2_staked_nxt = cur_bet_nxt;
                end
            end
            default: ;
        endcase

        if (close_round) begin
            cur_bet_nxt    = '0;
            p1_staked_nxt  = '0;
            p2_staked_nxt  = '0;
            cur_player_nxt = start_player;
            case (round)
                round_preflop: round_nxt = round_flop;
                round_flop:    round_nxt = round_turn;
                round_turn:    round_nxt = round_river;
                round_river: begin
                    settle_show = 1'b1;                         // Showdown.
                    end_hand    = 1'b1;
                end
                default:       round_nxt = round_preflop;
            endcase
        end

        if (end_hand) begin
            round_nxt      = round_preflop;
            pot_nxt        = '0;
            cur_bet_nxt    = '0;
            p1_staked_nxt  = '0;
            p2_staked_nxt  = '0;
            cur_player_nxt = next_starter;
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            round      <= round_preflop;
            cur_player <= player_1;
            hand_cnt   <= '0;
            pot        <= '0;
            cur_bet    <= '0;
            p1_staked  <= '0;
            p2_staked  <= '0;
        end else begin
            round      <= round_nxt;
            cur_player <= cur_player_nxt;
            hand_cnt   <= end_hand ? hand_cnt_nxt : hand_cnt;
            pot        <= pot_nxt;
            cur_bet    <= cur_bet_nxt;
            p1_staked  <= p1_staked_nxt;
            p2_staked  <= p2_staked_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== source/holdem_macros.svh ====
`ifndef HOLDEM_MACROS_SVH
`define HOLDEM_MACROS_SVH

// ----------------------------------------------------------------------
// Game rules.
// ----------------------------------------------------------------------
`define HOLDEM_CHIP_W           7       // Any chip amount.
`define HOLDEM_START_BALANCE    49      // Per player after reset.
`define HOLDEM_RAISE_STEP       5       // Added to the bet by one raise.
`define HOLDEM_HAND_CNT_W       8

// ----------------------------------------------------------------------
// Wishbone word addresses.
// ----------------------------------------------------------------------
`define HOLDEM_ADDR_STATUS      2'd0    // Write here to act.
`define HOLDEM_ADDR_POT         2'd1
`define HOLDEM_ADDR_P1          2'd2
`define HOLDEM_ADDR_P2          2'd3

`endif

// ==== source/holdem_pkg.sv ====
`default_nettype none

package holdem_pkg;

    // Betting rounds of one hand.
    typedef enum logic [1:0] {
        round_preflop,
        round_flop,
        round_turn,
        round_river
    } round_e;

    // Opcodes carried in dat_w[1:0] of a status write.
    typedef enum logic [1:0] {
        act_none,
        act_fold,
        act_check_call,
        act_raise
    } action_e;

    typedef enum logic {
        player_1,
        player_2
    } player_e;

endpackage

`default_nettype wire

// ==== source/holdem_top.sv ====
`default_nettype none
`include "holdem_macros.svh"

module holdem_top
    import holdem_pkg::*;
(
    input  wire         clk,
    input  wire         reset_d,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wire [1:0]   adr,
    input  wire [7:0]   dat_w,
    input  wire         hand_win,       // From the hand evaluator.
    input  wire         hand_tie,
    output logic        ack,
    output logic [7:0]  dat_r
);

    action_e                    act_kind;
    logic [`HOLDEM_CHIP_W-1:0]  act_amount;
    round_e                     round;
    player_e                    cur_player;
    player_e                    start_player;
    logic [`HOLDEM_CHIP_W-1:0]  pot;
    logic [`HOLDEM_CHIP_W-1:0]  cur_bet;
    logic [`HOLDEM_CHIP_W-1:0]  p1_staked;
    logic [`HOLDEM_CHIP_W-1:0]  p2_staked;
    player_e                    debit_player;
    logic [`HOLDEM_CHIP_W-1:0]  debit_amount;
    logic                       settle_fold;
    logic                       settle_show;
    player_e                    fold_winner;
    logic [`HOLDEM_CHIP_W-1:0]  settle_pot;
    logic [`HOLDEM_CHIP_W-1:0]  p1_balance;
    logic [`HOLDEM_CHIP_W-1:0]  p2_balance;

    action_decode u_decode (
        .clk(clk), .reset_d(reset_d), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .round(round), .cur_player(cur_player),
        .start_player(start_player), .pot(pot), .cur_bet(cur_bet),
        .p1_staked(p1_staked), .p2_staked(p2_staked), .p1_balance(p1_balance),
        .p2_balance(p2_balance), .ack(ack), .dat_r(dat_r),
        .act_kind(act_kind), .act_amount(act_amount)
    );

    bet_execute u_execute (
        .clk(clk), .reset_d(reset_d), .act_kind(act_kind), .act_amount(act_amount),
        .round(round), .cur_player(cur_player), .start_player(start_player),
        .pot(pot), .cur_bet(cur_bet), .p1_staked(p1_staked), .p2_staked(p2_staked),
        .debit_player(debit_player), .debit_amount(debit_amount),
        .settle_fold(settle_fold), .settle_show(settle_show),
        .fold_winner(fold_winner), .settle_pot(settle_pot)
    );

    pot_settle u_settle (
        .clk(clk), .reset_d(reset_d), .debit_player(debit_player),
        .debit_amount(debit_amount), .settle_fold(settle_fold),
        .settle_show(settle_show), .fold_winner(fold_winner),
        .settle_pot(settle_pot), .hand_win(hand_win), .hand_tie(hand_tie),
        .p1_balance(p1_balance), .p2_balance(p2_balance)
    );

endmodule

`default_nettype wire

// ==== source/pot_settle.sv ====
`default_nettype none
`include "holdem_macros.svh"

module pot_settle
    import holdem_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_d,
    input  wire player_e                debit_player,
    input  wire [`HOLDEM_CHIP_W-1:0]    debit_amount,
    input  wire                         settle_fold,
    input  wire                         settle_show,
    input  wire player_e                fold_winner,
    input  wire [`HOLDEM_CHIP_W-1:0]    settle_pot,
    input  wire                         hand_win,
    input  wire                         hand_tie,
    output logic [`HOLDEM_CHIP_W-1:0]   p1_balance,
    output logic [`HOLDEM_CHIP_W-1:0]   p2_balance
);

    logic [`HOLDEM_CHIP_W-1:0] half_pot;
    logic [`HOLDEM_CHIP_W-1:0] p1_debit;
    logic [`HOLDEM_CHIP_W-1:0] p2_debit;
    logic [`HOLDEM_CHIP_W-1:0] p1_credit;
    logic [`HOLDEM_CHIP_W-1:0] p2_credit;

    assign half_pot = settle_pot >> 1;                  // Odd chip is lost.
    assign p1_debit = (debit_player == player_1) ? debit_amount : '0;
    assign p2_debit = (debit_player == player_2) ? debit_amount : '0;

    // ----------------------------------------------------------------------
    // Payouts.
    // ----------------------------------------------------------------------
    always_comb begin
        p1_credit = '0;
        p2_credit = '0;
        if (settle_fold) begin
            if (fold_winner == player_1) begin
                p1_credit = settle_pot;
            end else begin
                p2_credit = settle_pot;
            end
        end else if (settle_show) begin
            if (hand_tie) begin
                p1_credit = half_pot;
                p2_credit = half_pot;
            end else if (hand_win) begin
                p1_credit = settle_pot;
            end else begin
                p2_credit = settle_pot;
            end
        end
    end

    // A river call is debited and paid back on the same edge.
    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            p1_balance <= `HOLDEM_CHIP_W'(`HOLDEM_START_BALANCE);
            p2_balance <= `HOLDEM_CHIP_W'(`HOLDEM_START_BALANCE);
        end else begin
            p1_balance <= p1_balance - p1_debit + p1_credit;
            p2_balance <= p2_balance - p2_debit + p2_credit;
        end
    end

endmodule

`default_nettype wire
